// ==== include/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Base opcodes
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// ALU operations seen by execute
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_SLL   4'd2
`define ALU_SLT   4'd3
`define ALU_SLTU  4'd4
`define ALU_XOR   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
`define ALU_OR    4'd8
`define ALU_AND   4'd9
`define ALU_PASSB 4'd10

`define PC_W        16
`define MUL_LATENCY 4

`endif

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////
  // Instruction word and its format views
  ////////////////////////////////////////

  // All views share opcode, rd, funct3, rs1 and rs2 bit positions
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_u;

endpackage

`default_nettype wire

// ==== logic/control_unit.sv ====
`default_nettype none
`include "decode_params.svh"

module control_unit (
  input  isa_pkg::instr_u ins,
  output logic [3:0]      alu_op,
  output logic            alusrc,
  output logic            memread,
  output logic            memwrite,
  output logic            regwrite,
  output logic            branch,
  output logic            jal,
  output logic            jalr,
  output logic            is_mul,
  output logic            uses_rs1,
  output logic            uses_rs2
);

  // ALU operation from funct3; alt is funct7 bit 5
  function automatic logic [3:0] alu_sel(input logic [2:0] f3, input logic alt,
                                         input logic allow_sub);
    case (f3)
      3'b000:  alu_sel = (alt && allow_sub) ? `ALU_SUB : `ALU_ADD;
      3'b001:  alu_sel = `ALU_SLL;
      3'b010:  alu_sel = `ALU_SLT;
      3'b011:  alu_sel = `ALU_SLTU;
      3'b100:  alu_sel = `ALU_XOR;
      3'b101:  alu_sel = alt ? `ALU_SRA : `ALU_SRL;
      3'b110:  alu_sel = `ALU_OR;
      default: alu_sel = `ALU_AND;
    endcase
  endfunction

  always_comb begin
    alu_op   = `ALU_ADD;
    alusrc   = 1'b0;
    memread  = 1'b0;
    memwrite = 1'b0;
    regwrite = 1'b0;
    branch   = 1'b0;
    jal      = 1'b0;
    jalr     = 1'b0;
    is_mul   = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (ins.r.opcode)
      `OP_REG: begin
        // M extension: only MUL is supported
        if (ins.r.funct7 == 7'b0000001) begin
          if (ins.r.funct3 == 3'b000) begin
            is_mul   = 1'b1;
            regwrite = 1'b1;
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
          end
        end else begin
          alu_op   = alu_sel(ins.r.funct3, ins.r.funct7[5], 1'b1);
          regwrite = 1'b1;
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      `OP_IMM: begin
        alu_op   = alu_sel(ins.r.funct3, ins.r.funct7[5], 1'b0);
        alusrc   = 1'b1;
        regwrite = 1'b1;
        uses_rs1 = 1'b1;
      end
      `OP_LOAD: begin
        alusrc   = 1'b1;
        memread  = 1'b1;
        regwrite = 1'b1;
        uses_rs1 = 1'b1;
      end
      `OP_STORE: begin
        alusrc   = 1'b1;
        memwrite = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      `OP_BRANCH: begin
        alu_op   = `ALU_SUB;
        branch   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      `OP_JAL: begin
        jal      = 1'b1;
        alusrc   = 1'b1;
        regwrite = 1'b1;
      end
      `OP_JALR: begin
        jalr     = 1'b1;
        alusrc   = 1'b1;
        regwrite = 1'b1;
        uses_rs1 = 1'b1;
      end
      `OP_LUI: begin
        alu_op   = `ALU_PASSB;
        alusrc   = 1'b1;
        regwrite = 1'b1;
      end
      `OP_AUIPC: begin
        alusrc   = 1'b1;
        regwrite = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
`default_nettype none
`include "decode_params.svh"

module imm_gen (
  input  isa_pkg::instr_u ins,
  output logic [31:0]     imm
);

  always_comb begin
    case (ins.r.opcode)
      // I format
      `OP_IMM, `OP_LOAD, `OP_JALR: begin
        imm = {{20{ins.i.imm11_0[11]}}, ins.i.imm11_0};
      end
      `OP_STORE: begin
        imm = {{20{ins.s.imm11_5[6]}}, ins.s.imm11_5, ins.s.imm4_0};
      end
      // B format, offset in halfwords
      `OP_BRANCH: begin
        imm = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
               ins.b.imm4_1, 1'b0};
      end
      `OP_LUI, `OP_AUIPC: begin
        imm = {ins.u.imm31_12, 12'h000};
      end
      `OP_JAL: begin
        imm = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
               ins.j.imm10_1, 1'b0};
      end
      // R-type and unknown opcodes
      default: imm = 32'h0000_0000;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
  input  logic [4:0] rs1_addr,
  input  logic [4:0] rs2_addr,
  input  logic       uses_rs1,
  input  logic       uses_rs2,
  input  logic       branch,
  input  logic       jalr,
  input  logic [4:0] id_ex_rd,
  input  logic       id_ex_regwrite,
  input  logic       id_ex_memread,
  input  logic [4:0] ex_mem_rd,
  input  logic       ex_mem_memread,
  output logic       hz
);

  logic idex_match;
  logic exmem_match;
  logic resolves_in_id;
  logic load_use;
  logic br_dep_idex;
  logic br_dep_exmem;

  // x0 never creates a dependency
  assign idex_match = (id_ex_rd != 5'd0) &&
                      ((uses_rs1 && (rs1_addr == id_ex_rd)) ||
                       (uses_rs2 && (rs2_addr == id_ex_rd)));

  assign exmem_match = (ex_mem_rd != 5'd0) &&
                       ((uses_rs1 && (rs1_addr == ex_mem_rd)) ||
                        (uses_rs2 && (rs2_addr == ex_mem_rd)));

  // Branches and JALR read operands here in decode
  assign resolves_in_id = branch || jalr;

  assign load_use     = id_ex_memread && idex_match;
  assign br_dep_idex  = resolves_in_id && id_ex_regwrite && idex_match;
  assign br_dep_exmem = resolves_in_id && ex_mem_memread && exmem_match;

  assign hz = load_use || br_dep_idex || br_dep_exmem;

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
`default_nettype none
`include "decode_params.svh"

module branch_unit (
  input  isa_pkg::instr_u  ins,
  input  logic [`PC_W-1:0] if_id_pc,
  input  logic [31:0]      imm,
  input  logic             branch,
  input  logic             jal,
  input  logic             jalr,
  input  logic [31:0]      rs1_data,
  input  logic [31:0]      rs2_data,
  input  logic [4:0]       ex_mem_rd,
  input  logic             ex_mem_regwrite,
  input  logic             ex_mem_memread,
  input  logic [31:0]      ex_mem_alures,
  input  logic [4:0]       mem_wb_rd,
  input  logic             mem_wb_regwrite,
  input  logic [31:0]      wb_res,
  output logic             branch_taken_raw,
  output logic [`PC_W-1:0] branch_target
);

  logic [31:0]      op1;
  logic [31:0]      op2;
  logic             cond;
  logic [31:0]      jalr_sum;
  logic [`PC_W-1:0] pc_sum;

  // EX/MEM result first, then WB, then the register file
  function automatic logic [31:0] fwd(input logic [4:0] addr, input logic [31:0] reg_val);
    if (ex_mem_regwrite && !ex_mem_memread && (ex_mem_rd != 5'd0) && (ex_mem_rd == addr))
      fwd = ex_mem_alures;
    else if (mem_wb_regwrite && (mem_wb_rd != 5'd0) && (mem_wb_rd == addr))
      fwd = wb_res;
    else
      fwd = reg_val;
  endfunction

  always_comb begin
    op1 = fwd(ins.r.rs1, rs1_data);
    op2 = fwd(ins.r.rs2, rs2_data);
  end

  ////////////////////////////////////////
  // Condition by funct3
  ////////////////////////////////////////
  always_comb begin
    case (ins.b.funct3)
      3'b000:  cond = (op1 == op2);
      3'b001:  cond = (op1 != op2);
      3'b100:  cond = ($signed(op1) < $signed(op2));
      3'b101:  cond = ($signed(op1) >= $signed(op2));
      3'b110:  cond = (op1 < op2);
      3'b111:  cond = (op1 >= op2);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken_raw = jal || jalr || (branch && cond);

  // Targets
  assign jalr_sum = op1 + imm;
  assign pc_sum   = if_id_pc + imm[`PC_W-1:0];

  assign branch_target = jalr ? {jalr_sum[`PC_W-1:1], 1'b0} : pc_sum;

endmodule

`default_nettype wire

// ==== logic/muldiv_timer.sv ====
`default_nettype none
`include "decode_params.svh"

module muldiv_timer #(
  parameter int latency = `MUL_LATENCY
) (
  input  logic bus,
  input  logic arst_n,
  input  logic start,
  input  logic hold,
  output logic busy,
  output logic mul_ready
);

  localparam int cnt_w = (latency > 1) ? $clog2(latency) : 1;

  logic [cnt_w-1:0] cnt;

  // Down counter, loaded with latency-1 so ready comes latency cycles after start
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (!hold) begin
      if (!busy) begin
        if (start) begin
          busy <= 1'b1;
          cnt  <= cnt_w'(latency - 1);
        end
      end else if (cnt == '0) begin
        // Multiply issues on this edge
        busy <= 1'b0;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  assign mul_ready = busy && (cnt == '0);

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none
`include "decode_params.svh"

module decode_stage (
  input  logic             bus,
  input  logic             arst_n,
  input  isa_pkg::instr_u  ins,
  input  logic [`PC_W-1:0] if_id_pc,
  input  logic [31:0]      rs1_data,
  input  logic [31:0]      rs2_data,
  input  logic [4:0]       ex_mem_rd,
  input  logic             ex_mem_regwrite,
  input  logic             ex_mem_memread,
  input  logic [31:0]      ex_mem_alures,
  input  logic [4:0]       mem_wb_rd,
  input  logic             mem_wb_regwrite,
  input  logic [31:0]      wb_res,
  input  logic             hold,
  output logic [4:0]       rs1_addr,
  output logic [4:0]       rs2_addr,
  output logic             stall,
  output logic             branch_taken,
  output logic [`PC_W-1:0] branch_target,
  output logic [3:0]       id_ex_alu_op,
  output logic             id_ex_alusrc,
  output logic             id_ex_memread,
  output logic             id_ex_memwrite,
  output logic             id_ex_regwrite,
  output logic             id_ex_mul,
  output logic [4:0]       id_ex_rs1,
  output logic [4:0]       id_ex_rs2,
  output logic [4:0]       id_ex_rd,
  output logic [31:0]      id_ex_rs1_data,
  output logic [31:0]      id_ex_rs2_data,
  output logic [31:0]      id_ex_imm,
  output logic [`PC_W-1:0] id_ex_pc
);

  logic [3:0]  dec_alu_op;
  logic        dec_alusrc;
  logic        dec_memread;
  logic        dec_memwrite;
  logic        dec_regwrite;
  logic        dec_branch;
  logic        dec_jal;
  logic        dec_jalr;
  logic        dec_mul;
  logic        dec_uses_rs1;
  logic        dec_uses_rs2;
  logic [31:0] imm;
  logic        hz;
  logic        branch_taken_raw;
  logic        mul_busy;
  logic        mul_ready;
  logic        flush_q;
  logic        live;

  assign rs1_addr = ins.r.rs1;
  assign rs2_addr = ins.r.rs2;

  control_unit u_ctrl (
    .ins      (ins),
    .alu_op   (dec_alu_op),
    .alusrc   (dec_alusrc),
    .memread  (dec_memread),
    .memwrite (dec_memwrite),
    .regwrite (dec_regwrite),
    .branch   (dec_branch),
    .jal      (dec_jal),
    .jalr     (dec_jalr),
    .is_mul   (dec_mul),
    .uses_rs1 (dec_uses_rs1),
    .uses_rs2 (dec_uses_rs2)
  );

  imm_gen u_imm (
    .ins (ins),
    .imm (imm)
  );

  // Squashed instruction must not stall or start the multiplier
  assign live = !flush_q;

  hazard_unit u_hz (
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .uses_rs1       (dec_uses_rs1 && live),
    .uses_rs2       (dec_uses_rs2 && live),
    .branch         (dec_branch && live),
    .jalr           (dec_jalr && live),
    .id_ex_rd       (id_ex_rd),
    .id_ex_regwrite (id_ex_regwrite),
    .id_ex_memread  (id_ex_memread),
    .ex_mem_rd      (ex_mem_rd),
    .ex_mem_memread (ex_mem_memread),
    .hz             (hz)
  );

  branch_unit u_br (
    .ins              (ins),
    .if_id_pc         (if_id_pc),
    .imm              (imm),
    .branch           (dec_branch),
    .jal              (dec_jal),
    .jalr             (dec_jalr),
    .rs1_data         (rs1_data),
    .rs2_data         (rs2_data),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_regwrite  (ex_mem_regwrite),
    .ex_mem_memread   (ex_mem_memread),
    .ex_mem_alures    (ex_mem_alures),
    .mem_wb_rd        (mem_wb_rd),
    .mem_wb_regwrite  (mem_wb_regwrite),
    .wb_res           (wb_res),
    .branch_taken_raw (branch_taken_raw),
    .branch_target    (branch_target)
  );

  muldiv_timer #(.latency(`MUL_LATENCY)) u_mul (
    .bus       (bus),
    .arst_n    (arst_n),
    .start     (dec_mul && live && !hz && !mul_busy),
    .hold      (hold),
    .busy      (mul_busy),
    .mul_ready (mul_ready)
  );

  ////////////////////////////////////////
  // Stall merge and branch gating
  ////////////////////////////////////////
  assign stall = hz || (dec_mul && live && !mul_ready);

  // Operands not ready yet, so no redirect while stalled
  assign branch_taken = branch_taken_raw && live && !stall;

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_alu_op   <= `ALU_ADD;
      id_ex_alusrc   <= 1'b0;
      id_ex_memread  <= 1'b0;
      id_ex_memwrite <= 1'b0;
      id_ex_regwrite <= 1'b0;
      id_ex_mul      <= 1'b0;
      id_ex_rs1      <= 5'd0;
      id_ex_rs2      <= 5'd0;
      id_ex_rd       <= 5'd0;
      flush_q        <= 1'b0;
    end else if (!hold) begin
      flush_q <= branch_taken;
      if (stall || flush_q) begin
        // Bubble
        id_ex_alu_op   <= `ALU_ADD;
        id_ex_alusrc   <= 1'b0;
        id_ex_memread  <= 1'b0;
        id_ex_memwrite <= 1'b0;
        id_ex_regwrite <= 1'b0;
        id_ex_mul      <= 1'b0;
        id_ex_rs1      <= 5'd0;
        id_ex_rs2      <= 5'd0;
        id_ex_rd       <= 5'd0;
      end else begin
        id_ex_alu_op   <= dec_alu_op;
        id_ex_alusrc   <= dec_alusrc;
        id_ex_memread  <= dec_memread;
        id_ex_memwrite <= dec_memwrite;
        id_ex_regwrite <= dec_regwrite;
        id_ex_mul      <= dec_mul;
        id_ex_rs1      <= rs1_addr;
        id_ex_rs2      <= rs2_addr;
        id_ex_rd       <= ins.r.rd;
      end
    end
  end

  // Payload, PC passes through bubbles too
  always_ff @(posedge bus) begin
    if (!hold) begin
      id_ex_rs1_data <= rs1_data;
      id_ex_rs2_data <= rs2_data;
      id_ex_imm      <= imm;
      id_ex_pc       <= if_id_pc;
    end
  end

endmodule

`default_nettype wire

// ==== verif/decode_asserts.sv ====
`default_nettype none

module decode_asserts (
  input logic       bus,
  input logic       arst_n,
  input logic       hold,
  input logic       stall,
  input logic       branch_taken,
  input logic       mul_ready,
  input logic       id_ex_regwrite,
  input logic       id_ex_memread,
  input logic       id_ex_memwrite,
  input logic       id_ex_mul,
  input logic [4:0] id_ex_rd
);

  int fails = 0;

  // Multiply issues on the edge where the timer is ready
  a_mul_issue: assert property (@(posedge bus) disable iff (!arst_n)
    (mul_ready && !hold) |=> id_ex_mul)
    else begin
      $error("MUL not issued when the timer was ready");
      fails++;
    end

  // Instruction after a taken branch reaches ID/EX as a bubble
  a_squash: assert property (@(posedge bus) disable iff (!arst_n)
    (branch_taken && !hold) ##1 !hold
      |=> !(id_ex_regwrite || id_ex_memread || id_ex_memwrite || id_ex_mul))
    else begin
      $error("taken branch not squashed");
      fails++;
    end

  // Stall loads a bubble
  a_stall_bubble: assert property (@(posedge bus) disable iff (!arst_n)
    (stall && !hold) |=> !(id_ex_regwrite || id_ex_memread || id_ex_memwrite || id_ex_mul))
    else begin
      $error("stall did not load a bubble");
      fails++;
    end

  a_hold_freeze: assert property (@(posedge bus) disable iff (!arst_n)
    hold |=> ($stable(id_ex_rd) && $stable(id_ex_regwrite) && $stable(id_ex_mul)))
    else begin
      $error("ID/EX changed under hold");
      fails++;
    end

endmodule

bind decode_stage decode_asserts asserts0 (
  .bus            (bus),
  .arst_n         (arst_n),
  .hold           (hold),
  .stall          (stall),
  .branch_taken   (branch_taken),
  .mul_ready      (mul_ready),
  .id_ex_regwrite (id_ex_regwrite),
  .id_ex_memread  (id_ex_memread),
  .id_ex_memwrite (id_ex_memwrite),
  .id_ex_mul      (id_ex_mul),
  .id_ex_rd       (id_ex_rd)
);

`default_nettype wire

// ==== verif/decode_tb.sv ====
`default_nettype none
`include "decode_params.svh"

module decode_tb;

  localparam int n_tests      = 6;
  localparam int cycle_budget = 200;

  logic             bus;
  logic             arst_n;
  isa_pkg::instr_u  ins;
  logic [`PC_W-1:0] if_id_pc;
  logic [31:0]      rs1_data;
  logic [31:0]      rs2_data;
  logic [4:0]       ex_mem_rd;
  logic             ex_mem_regwrite;
  logic             ex_mem_memread;
  logic [31:0]      ex_mem_alures;
  logic [4:0]       mem_wb_rd;
  logic             mem_wb_regwrite;
  logic [31:0]      wb_res;
  logic             hold;
  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic             stall;
  logic             branch_taken;
  logic [`PC_W-1:0] branch_target;
  logic [3:0]       id_ex_alu_op;
  logic             id_ex_alusrc;
  logic             id_ex_memread;
  logic             id_ex_memwrite;
  logic             id_ex_regwrite;
  logic             id_ex_mul;
  logic [4:0]       id_ex_rs1;
  logic [4:0]       id_ex_rs2;
  logic [4:0]       id_ex_rd;
  logic [31:0]      id_ex_rs1_data;
  logic [31:0]      id_ex_rs2_data;
  logic [31:0]      id_ex_imm;
  logic [`PC_W-1:0] id_ex_pc;
  int               errors;
  int               seed_val;

  decode_stage dut0 (.*);

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;
  end

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////
  function automatic isa_pkg::instr_u r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] op);
    isa_pkg::instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = op;
    return w;
  endfunction

  function automatic isa_pkg::instr_u i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    isa_pkg::instr_u w;
    w.i.imm11_0 = imm;
    w.i.rs1     = rs1;
    w.i.funct3  = f3;
    w.i.rd      = rd;
    w.i.opcode  = op;
    return w;
  endfunction

  function automatic isa_pkg::instr_u s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    isa_pkg::instr_u w;
    w.s.imm11_5 = imm[11:5];
    w.s.rs2     = rs2;
    w.s.rs1     = rs1;
    w.s.funct3  = f3;
    w.s.imm4_0  = imm[4:0];
    w.s.opcode  = `OP_STORE;
    return w;
  endfunction

  function automatic isa_pkg::instr_u b_word(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    isa_pkg::instr_u w;
    w.b.imm12   = off[12];
    w.b.imm10_5 = off[10:5];
    w.b.rs2     = rs2;
    w.b.rs1     = rs1;
    w.b.funct3  = f3;
    w.b.imm4_1  = off[4:1];
    w.b.imm11   = off[11];
    w.b.opcode  = `OP_BRANCH;
    return w;
  endfunction

  function automatic isa_pkg::instr_u j_word(input logic [20:0] off, input logic [4:0] rd);
    isa_pkg::instr_u w;
    w.j.imm20    = off[20];
    w.j.imm10_1  = off[10:1];
    w.j.imm11    = off[11];
    w.j.imm19_12 = off[19:12];
    w.j.rd       = rd;
    w.j.opcode   = `OP_JAL;
    return w;
  endfunction

  function automatic isa_pkg::instr_u nop();
    return i_word(12'd0, 5'd0, 3'd0, 5'd0, `OP_IMM);
  endfunction

  // Expected branch outcome per funct3
  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    logic eq;
    logic lt;
    logic ltu;
    eq  = (a == b);
    ltu = (a < b);
    // Signs differ, so the negative one is smaller
    lt  = (a[31] != b[31]) ? a[31] : ltu;
    case (f3)
      3'd0:    return eq;
      3'd1:    return !eq;
      3'd4:    return lt;
      3'd5:    return !lt;
      3'd6:    return ltu;
      3'd7:    return !ltu;
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic stop_run();
    errors++;
    $display("** FAIL **");
    $fatal(1, "stopping at first mismatch");
  endtask

  // Flags are {alusrc, memread, memwrite, regwrite, mul}
  task automatic check_ctrl(input string what, input logic [3:0] exp_alu,
                            input logic [4:0] exp_flags);
    logic [4:0] got;
    got = {id_ex_alusrc, id_ex_memread, id_ex_memwrite, id_ex_regwrite, id_ex_mul};
    if (id_ex_alu_op !== exp_alu || got !== exp_flags) begin
      $display("** Error @%0t: %s alu_op %h flags %b, expected %h %b",
               $time, what, id_ex_alu_op, got, exp_alu, exp_flags);
      stop_run();
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pc(input string what, input logic [`PC_W-1:0] got,
                          input logic [`PC_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Watch the bound assertions
  always @(negedge bus) begin
    if (dut0.asserts0.fails != 0) begin
      $display("A concurrent assertion in the bound checker failed");
      stop_run();
    end
  end

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////
  task automatic present(input isa_pkg::instr_u w);
    @(posedge bus);
    ins <= w;
    @(negedge bus);
  endtask

  // Instruction, then a NOP, then look at ID/EX
  task automatic issue_check(input string what, input isa_pkg::instr_u w,
                             input logic [3:0] exp_alu, input logic [4:0] exp_flags,
                             input logic [31:0] exp_imm, input logic [4:0] exp_rd);
    present(w);
    present(nop());
    check_ctrl(what, exp_alu, exp_flags);
    check_word({what, " imm"}, id_ex_imm, exp_imm);
    check_word({what, " rd"}, {27'd0, id_ex_rd}, {27'd0, exp_rd});
  endtask

  // Returns the number of cycles stall stayed high
  task automatic run_mul(input int hold_len, output int n);
    n = 0;
    @(posedge bus);
    ins  <= r_word(7'd1, 5'd15, 5'd14, 3'd0, 5'd13, `OP_REG);
    hold <= 1'b0;
    @(negedge bus);
    while (stall && n < 40) begin
      n++;
      @(posedge bus);
      hold <= (n >= 2 && n < 2 + hold_len);
      @(negedge bus);
    end
    if (stall) begin
      $display("MUL never released the stall");
      stop_run();
    end
    @(posedge bus);
    ins  <= nop();
    hold <= 1'b0;
    @(negedge bus);
    check_flag("id_ex_mul", id_ex_mul, 1'b1);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic basic_decode();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = $urandom;
    r2 = $urandom;
    check_ctrl("reset", `ALU_ADD, 5'b00000);
    @(posedge bus);
    rs1_data <= r1;
    rs2_data <= r2;
    issue_check("addi", i_word(12'hff9, 5'd1, 3'd0, 5'd5, `OP_IMM), `ALU_ADD, 5'b10010,
                32'hffff_fff9, 5'd5);
    check_word("addi rs1 data", id_ex_rs1_data, r1);
    check_word("addi rs2 data", id_ex_rs2_data, r2);
    issue_check("sub", r_word(7'b0100000, 5'd3, 5'd2, 3'd0, 5'd6, `OP_REG), `ALU_SUB,
                5'b00010, 32'd0, 5'd6);
    check_word("sub rs1", {27'd0, id_ex_rs1}, 32'd2);
    check_word("sub rs2", {27'd0, id_ex_rs2}, 32'd3);
    issue_check("lui", i_word(12'hcde, 5'h0a, 3'd5, 5'd3, `OP_LUI), `ALU_PASSB, 5'b10010,
                32'hcde5_5000, 5'd3);
    issue_check("lw", i_word(12'd12, 5'd2, 3'd2, 5'd4, `OP_LOAD), `ALU_ADD, 5'b11010,
                32'd12, 5'd4);
    // Store rd field carries imm[4:0]
    issue_check("sw", s_word(12'hffc, 5'd6, 5'd2, 3'd2), `ALU_ADD, 5'b10100,
                32'hffff_fffc, 5'd28);
  endtask

  task automatic load_use_stall();
    present(i_word(12'd0, 5'd1, 3'd2, 5'd7, `OP_LOAD));
    present(r_word(7'd0, 5'd2, 5'd7, 3'd0, 5'd8, `OP_REG));
    check_word("rs1 addr", {27'd0, rs1_addr}, 32'd7);
    check_word("rs2 addr", {27'd0, rs2_addr}, 32'd2);
    check_flag("load-use stall", stall, 1'b1);
    @(posedge bus);
    @(negedge bus);
    check_ctrl("load-use bubble", `ALU_ADD, 5'b00000);
    check_flag("stall cleared", stall, 1'b0);
    present(nop());
    check_ctrl("add after bubble", `ALU_ADD, 5'b00010);
    check_word("add rd", {27'd0, id_ex_rd}, 32'd8);
  endtask

  task automatic branch_resolve();
    logic [2:0]       f3s [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      junk;
    logic [12:0]      off;
    logic [`PC_W-1:0] pc;
    logic             exp_t;
    for (int k = 0; k < 6; k++) begin
      for (int src = 0; src < 3; src++) begin
        a     = $urandom;
        b     = ($urandom % 3 == 0) ? a : $urandom;
        junk  = $urandom;
        off   = 13'($urandom) & 13'h1ffe;
        pc    = `PC_W'($urandom) & 16'hfffc;
        exp_t = branch_cond(f3s[k], a, b);
        @(posedge bus);
        ins      <= b_word(off, 5'd11, 5'd10, f3s[k]);
        if_id_pc <= pc;
        if (src == 0) begin
          rs1_data <= a;
          rs2_data <= b;
        end else if (src == 1) begin
          // rs1 from EX/MEM, rs2 from WB
          ex_mem_rd       <= 5'd10;
          ex_mem_regwrite <= 1'b1;
          ex_mem_alures   <= a;
          rs1_data        <= junk;
          mem_wb_rd       <= 5'd11;
          mem_wb_regwrite <= 1'b1;
          wb_res          <= b;
          rs2_data        <= ~b;
        end else begin
          // EX/MEM wins over WB for rs2
          ex_mem_rd       <= 5'd11;
          ex_mem_regwrite <= 1'b1;
          ex_mem_alures   <= b;
          mem_wb_rd       <= 5'd11;
          mem_wb_regwrite <= 1'b1;
          wb_res          <= junk;
          rs1_data        <= a;
          rs2_data        <= ~b;
        end
        @(negedge bus);
        check_flag("branch taken", branch_taken, exp_t);
        if (exp_t)
          check_pc("branch target", branch_target, pc + {{3{off[12]}}, off});
        @(posedge bus);
        ins             <= i_word(12'd1, 5'd0, 3'd0, 5'd9, `OP_IMM);
        ex_mem_regwrite <= 1'b0;
        mem_wb_regwrite <= 1'b0;
        @(negedge bus);
        present(nop());
        check_ctrl("after branch", `ALU_ADD, exp_t ? 5'b00000 : 5'b10010);
      end
    end
  endtask

  task automatic jump_targets();
    logic [20:0]      joff;
    logic [11:0]      jimm;
    logic [31:0]      r;
    logic [31:0]      sum;
    logic [`PC_W-1:0] pc;
    joff = 21'($urandom) & 21'h1ffffe;
    pc   = `PC_W'($urandom) & 16'hfffc;
    @(posedge bus);
    ins      <= j_word(joff, 5'd1);
    if_id_pc <= pc;
    @(negedge bus);
    check_flag("jal taken", branch_taken, 1'b1);
    check_pc("jal target", branch_target, pc + joff[15:0]);
    present(nop());
    present(nop());
    r    = $urandom;
    jimm = 12'($urandom);
    sum  = r + {{20{jimm[11]}}, jimm};
    @(posedge bus);
    ins      <= i_word(jimm, 5'd12, 3'd0, 5'd1, `OP_JALR);
    rs1_data <= r;
    @(negedge bus);
    check_flag("jalr taken", branch_taken, 1'b1);
    check_pc("jalr target", branch_target, sum[`PC_W-1:0] & 16'hfffe);
    present(nop());
    present(nop());
    // JALR right behind an ALU write to its base register
    present(i_word(12'd5, 5'd0, 3'd0, 5'd12, `OP_IMM));
    present(i_word(jimm, 5'd12, 3'd0, 5'd1, `OP_JALR));
    check_flag("jalr dep stall", stall, 1'b1);
    check_flag("jalr held back", branch_taken, 1'b0);
    @(posedge bus);
    @(negedge bus);
    check_flag("jalr stall gone", stall, 1'b0);
    check_flag("jalr taken late", branch_taken, 1'b1);
    check_pc("jalr late target", branch_target, sum[`PC_W-1:0] & 16'hfffe);
    present(nop());
    present(nop());
  endtask

  task automatic mul_latency();
    int n;
    run_mul(0, n);
    check_word("mul stall cycles", n, `MUL_LATENCY);
  endtask

  task automatic hold_freeze();
    int n;
    @(posedge bus);
    ins      <= i_word(12'd33, 5'd0, 3'd0, 5'd16, `OP_IMM);
    if_id_pc <= 16'h0400;
    rs1_data <= 32'h1357_9bdf;
    rs2_data <= 32'h2468_ace0;
    // ADDI enters ID/EX on this edge, then the stage freezes
    @(posedge bus);
    hold     <= 1'b1;
    ins      <= i_word(12'd44, 5'd2, 3'd2, 5'd17, `OP_LOAD);
    if_id_pc <= 16'h0800;
    rs1_data <= 32'h0;
    rs2_data <= 32'h0;
    for (int i = 0; i < 3; i++) begin
      @(negedge bus);
      check_ctrl("held ctrl", `ALU_ADD, 5'b10010);
      check_word("held imm", id_ex_imm, 32'd33);
      check_word("held rd", {27'd0, id_ex_rd}, 32'd16);
      check_word("held rs1", {27'd0, id_ex_rs1}, 32'd0);
      check_word("held rs2", {27'd0, id_ex_rs2}, 32'd1);
      check_word("held rs1 data", id_ex_rs1_data, 32'h1357_9bdf);
      check_word("held rs2 data", id_ex_rs2_data, 32'h2468_ace0);
      check_pc("held pc", id_ex_pc, 16'h0400);
    end
    @(posedge bus);
    hold <= 1'b0;
    ins  <= nop();
    @(negedge bus);
    present(nop());
    check_word("released rd", {27'd0, id_ex_rd}, 32'd0);
    check_pc("released pc", id_ex_pc, 16'h0800);
    run_mul(2, n);
    check_word("held mul stall cycles", n, `MUL_LATENCY + 2);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////
  initial begin
    #(n_tests * cycle_budget * 8);
    $display("Timeout: the tests did not finish in time");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    errors          = 0;
    seed_val        = $urandom(32'hbde4);
    arst_n          = 1'b0;
    ins             = nop();
    if_id_pc        = '0;
    rs1_data        = '0;
    rs2_data        = '0;
    ex_mem_rd       = '0;
    ex_mem_regwrite = 1'b0;
    ex_mem_memread  = 1'b0;
    ex_mem_alures   = '0;
    mem_wb_rd       = '0;
    mem_wb_regwrite = 1'b0;
    wb_res          = '0;
    hold            = 1'b0;
    repeat (2) @(posedge bus);
    arst_n <= 1'b1;
    @(negedge bus);
    basic_decode();
    load_use_stall();
    branch_resolve();
    jump_targets();
    mul_latency();
    hold_freeze();
    if (errors == 0 && dut0.asserts0.fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
logic/isa_pkg.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/hazard_unit.sv
logic/branch_unit.sv
logic/muldiv_timer.sv
logic/decode_stage.sv
verif/decode_asserts.sv
verif/decode_tb.sv

// ==== Bender.yml ====
package:
  name: rv32_decode

sources:
  - include_dirs:
      - include
    files:
      - logic/isa_pkg.sv
      - logic/control_unit.sv
      - logic/imm_gen.sv
      - logic/hazard_unit.sv
      - logic/branch_unit.sv
      - logic/muldiv_timer.sv
      - logic/decode_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/decode_asserts.sv
      - verif/decode_tb.sv
